// File: logic/pipePkg.sv
package pipePkg;

    // Datapath and register file sizes.
    parameter int dataWidth    = 32;
    parameter int regAddrWidth = 5;
    parameter int opWidth      = 6;
    parameter int excWidth     = 5;

    // Primary opcode field, bits 31..26 of the instruction word.
    typedef enum logic [opWidth-1:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opAddi    = 6'h08,
        opOri     = 6'h0d,
        opLui     = 6'h0f
    } opcodeT;

    // Function code of the R-type add.
    parameter logic [5:0] functAdd = 6'd32;

    // Exception codes as reported in the cause field.
    parameter logic [excWidth-1:0] excNone = 5'd0;
    parameter logic [excWidth-1:0] excRi   = 5'd10;
    parameter logic [excWidth-1:0] excOv   = 5'd12;

    // Fixed fetch addresses.
    parameter logic [dataWidth-1:0] resetPc   = 32'h0000_3000;
    parameter logic [dataWidth-1:0] handlerPc = 32'h0000_4184;

endpackage

// File: logic/regFile.sv
module regFile (
    input  logic                             clk,
    input  logic                             arstN,
    input  logic [pipePkg::regAddrWidth-1:0] rdAddrA,
    input  logic [pipePkg::regAddrWidth-1:0] rdAddrB,
    input  logic                             wbEn,
    input  logic [pipePkg::regAddrWidth-1:0] wbAddr,
    input  logic [pipePkg::dataWidth-1:0]    wbData,
    output logic [pipePkg::dataWidth-1:0]    rdDataA,
    output logic [pipePkg::dataWidth-1:0]    rdDataB
);

    localparam int numRegs = 1 << pipePkg::regAddrWidth;

    logic [pipePkg::dataWidth-1:0] regs [numRegs];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && (wbAddr != '0)) begin
            regs[wbAddr] <= wbData;
        end
    end

    // Register 0 is hardwired to zero.
    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

// File: logic/fetchStage.sv
module fetchStage (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          insValid,
    input  logic [pipePkg::dataWidth-1:0] insWord,
    input  logic                          flushReq,
    input  logic                          jumpValid,
    input  logic [pipePkg::dataWidth-1:0] jumpTarget,
    output logic                          fdValid,
    output logic [pipePkg::dataWidth-1:0] fdIns,
    output logic [pipePkg::dataWidth-1:0] fdPc4,
    output logic                          fdBd,
    output logic [pipePkg::dataWidth-1:0] fetchPc
);

    logic [pipePkg::dataWidth-1:0] pcReg;
    logic [pipePkg::dataWidth-1:0] slotTarget;
    logic                          slotPending;
    logic                          inSlot;

    // The next accepted word is a delay slot.
    assign inSlot  = jumpValid || slotPending;
    assign fetchPc = pcReg;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pcReg       <= pipePkg::resetPc;
            slotPending <= 1'b0;
            fdValid     <= 1'b0;
        end else if (flushReq) begin
            pcReg       <= pipePkg::handlerPc;
            slotPending <= 1'b0;
            fdValid     <= 1'b0;
        end else begin
            fdValid <= insValid;
            if (insValid) begin
                // After the delay slot the counter jumps to the target.
                if (inSlot) begin
                    pcReg <= jumpValid ? jumpTarget : slotTarget;
                end else begin
                    pcReg <= pcReg + 32'd4;
                end
                slotPending <= 1'b0;
            end else if (jumpValid) begin
                slotPending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (jumpValid) begin
            slotTarget <= jumpTarget;
        end
        if (insValid) begin
            fdIns <= insWord;
            fdPc4 <= pcReg + 32'd4;
            fdBd  <= inSlot;
        end
    end

endmodule

// File: logic/decodeStage.sv
module decodeStage (
    input  logic                             clk,
    input  logic                             arstN,
    input  logic                             fdValid,
    input  logic [pipePkg::dataWidth-1:0]    fdIns,
    input  logic [pipePkg::dataWidth-1:0]    fdPc4,
    input  logic                             fdBd,
    input  logic [pipePkg::dataWidth-1:0]    rdDataA,
    input  logic [pipePkg::dataWidth-1:0]    rdDataB,
    input  logic                             exValid,
    input  logic [pipePkg::regAddrWidth-1:0] exDest,
    input  logic [pipePkg::dataWidth-1:0]    exResult,
    input  logic                             wbEn,
    input  logic [pipePkg::regAddrWidth-1:0] wbAddr,
    input  logic [pipePkg::dataWidth-1:0]    wbData,
    input  logic                             flushReq,
    output logic [pipePkg::regAddrWidth-1:0] rdAddrA,
    output logic [pipePkg::regAddrWidth-1:0] rdAddrB,
    output logic                             jumpValid,
    output logic [pipePkg::dataWidth-1:0]    jumpTarget,
    output logic                             deValid,
    output pipePkg::opcodeT                  deOp,
    output logic [pipePkg::dataWidth-1:0]    deA,
    output logic [pipePkg::dataWidth-1:0]    deB,
    output logic [pipePkg::regAddrWidth-1:0] deDest,
    output logic [pipePkg::dataWidth-1:0]    dePc4,
    output logic [pipePkg::excWidth-1:0]     deExc,
    output logic                             deBd
);

    pipePkg::opcodeT                  op;
    pipePkg::opcodeT                  opNext;
    logic [pipePkg::regAddrWidth-1:0] destNext;
    logic [pipePkg::dataWidth-1:0]    opA;
    logic [pipePkg::dataWidth-1:0]    opB;
    logic [pipePkg::dataWidth-1:0]    bNext;
    logic                             reserved;

    assign op      = pipePkg::opcodeT'(fdIns[31:26]);
    assign rdAddrA = fdIns[25:21];
    assign rdAddrB = fdIns[20:16];

    assign jumpValid  = fdValid && (op == pipePkg::opJ);
    assign jumpTarget = {fdPc4[31:28], fdIns[25:0], 2'b00};

    // Execute result wins over commit result, then the register file.
    always_comb begin
        if (exValid && (exDest != '0) && (exDest == rdAddrA)) opA = exResult;
        else if (wbEn && (wbAddr == rdAddrA))                  opA = wbData;
        else                                                   opA = rdDataA;
        if (exValid && (exDest != '0) && (exDest == rdAddrB)) opB = exResult;
        else if (wbEn && (wbAddr == rdAddrB))                  opB = wbData;
        else                                                   opB = rdDataB;
    end

    always_comb begin
        opNext   = op;
        destNext = '0;
        bNext    = {16'h0000, fdIns[15:0]};
        reserved = 1'b0;
        case (op)
            pipePkg::opSpecial: begin
                destNext = fdIns[15:11];
                bNext    = opB;
                reserved = (fdIns[5:0] != pipePkg::functAdd);
            end
            pipePkg::opAddi: begin
                destNext = fdIns[20:16];
                bNext    = {{16{fdIns[15]}}, fdIns[15:0]};
            end
            pipePkg::opOri,
            pipePkg::opLui: destNext = fdIns[20:16];
            pipePkg::opJ:   destNext = '0;
            default:        reserved = 1'b1;
        endcase
        if (reserved) begin
            opNext   = pipePkg::opSpecial;
            destNext = '0;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            deValid <= 1'b0;
        end else begin
            deValid <= fdValid && !flushReq;
        end
    end

    always_ff @(posedge clk) begin
        deOp   <= opNext;
        deA    <= opA;
        deB    <= bNext;
        deDest <= destNext;
        dePc4  <= fdPc4;
        deExc  <= reserved ? pipePkg::excRi : pipePkg::excNone;
        deBd   <= fdBd;
    end

endmodule

// File: logic/executeStage.sv
module executeStage (
    input  logic                             clk,
    input  logic                             arstN,
    input  logic                             deValid,
    input  pipePkg::opcodeT                  deOp,
    input  logic [pipePkg::dataWidth-1:0]    deA,
    input  logic [pipePkg::dataWidth-1:0]    deB,
    input  logic [pipePkg::regAddrWidth-1:0] deDest,
    input  logic [pipePkg::dataWidth-1:0]    dePc4,
    input  logic [pipePkg::excWidth-1:0]     deExc,
    input  logic                             deBd,
    input  logic                             flushReq,
    output logic                             exValid,
    output logic [pipePkg::regAddrWidth-1:0] exDest,
    output logic [pipePkg::dataWidth-1:0]    exResult,
    output logic                             emValid,
    output logic [pipePkg::dataWidth-1:0]    emResult,
    output logic [pipePkg::regAddrWidth-1:0] emDest,
    output logic [pipePkg::dataWidth-1:0]    emPc4,
    output logic [pipePkg::excWidth-1:0]     emExc,
    output logic                             emBd
);

    logic [pipePkg::dataWidth-1:0] sum;
    logic                          isAdd;
    logic                          overflow;
    logic [pipePkg::excWidth-1:0]  excNext;

    assign sum      = deA + deB;
    assign isAdd    = (deOp == pipePkg::opSpecial) || (deOp == pipePkg::opAddi);
    // Signed overflow when both operands agree in sign and the sum does not.
    assign overflow = isAdd && (deA[31] == deB[31]) && (sum[31] != deA[31]);

    always_comb begin
        case (deOp)
            pipePkg::opSpecial,
            pipePkg::opAddi: exResult = sum;
            pipePkg::opOri:  exResult = deA | deB;
            pipePkg::opLui:  exResult = {deB[15:0], 16'h0000};
            default:         exResult = '0;
        endcase
    end

    // An earlier exception code takes precedence.
    assign excNext = (deExc != pipePkg::excNone) ? deExc :
                     (overflow ? pipePkg::excOv : pipePkg::excNone);

    assign exValid = deValid && (excNext == pipePkg::excNone);
    assign exDest  = deDest;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            emValid <= 1'b0;
        end else begin
            emValid <= deValid && !flushReq;
        end
    end

    always_ff @(posedge clk) begin
        emResult <= exResult;
        emDest   <= deDest;
        emPc4    <= dePc4;
        emExc    <= excNext;
        emBd     <= deBd;
    end

endmodule

// File: logic/commitUnit.sv
module commitUnit (
    input  logic                             emValid,
    input  logic [pipePkg::dataWidth-1:0]    emResult,
    input  logic [pipePkg::regAddrWidth-1:0] emDest,
    input  logic [pipePkg::dataWidth-1:0]    emPc4,
    input  logic [pipePkg::excWidth-1:0]     emExc,
    input  logic                             emBd,
    output logic                             wbEn,
    output logic [pipePkg::regAddrWidth-1:0] wbAddr,
    output logic [pipePkg::dataWidth-1:0]    wbData,
    output logic                             flushReq,
    output logic                             retireValid,
    output logic [pipePkg::dataWidth-1:0]    retirePc,
    output logic [pipePkg::regAddrWidth-1:0] retireDest,
    output logic [pipePkg::dataWidth-1:0]    retireResult,
    output logic                             excValid,
    output logic [pipePkg::excWidth-1:0]     excCode,
    output logic [pipePkg::dataWidth-1:0]    excEpc,
    output logic                             excBd
);

    logic hasExc;

    assign hasExc = (emExc != pipePkg::excNone);

    // Clean words retire.
    assign retireValid  = emValid && !hasExc;
    assign retirePc     = emPc4 - 32'd4;
    assign retireDest   = emDest;
    assign retireResult = emResult;

    assign wbEn   = retireValid && (emDest != '0);
    assign wbAddr = emDest;
    assign wbData = emResult;

    // Faulting words flush everything younger.
    assign excValid = emValid && hasExc;
    assign flushReq = excValid;
    assign excCode  = emExc;
    assign excBd    = emBd;
    // EPC points at the jump when the fault sits in its delay slot.
    assign excEpc   = emBd ? (emPc4 - 32'd8) : (emPc4 - 32'd4);

endmodule

// File: logic/pipeCore.sv
module pipeCore (
    input  logic                             clk,
    input  logic                             arstN,
    input  logic                             insValid,
    input  logic [pipePkg::dataWidth-1:0]    insWord,
    output logic                             retireValid,
    output logic [pipePkg::dataWidth-1:0]    retirePc,
    output logic [pipePkg::regAddrWidth-1:0] retireDest,
    output logic [pipePkg::dataWidth-1:0]    retireResult,
    output logic                             excValid,
    output logic [pipePkg::excWidth-1:0]     excCode,
    output logic [pipePkg::dataWidth-1:0]    excEpc,
    output logic                             excBd,
    output logic [pipePkg::dataWidth-1:0]    fetchPc
);

    logic                             fdValid;
    logic [pipePkg::dataWidth-1:0]    fdIns;
    logic [pipePkg::dataWidth-1:0]    fdPc4;
    logic                             fdBd;
    logic                             jumpValid;
    logic [pipePkg::dataWidth-1:0]    jumpTarget;
    logic [pipePkg::regAddrWidth-1:0] rdAddrA;
    logic [pipePkg::regAddrWidth-1:0] rdAddrB;
    logic [pipePkg::dataWidth-1:0]    rdDataA;
    logic [pipePkg::dataWidth-1:0]    rdDataB;
    logic                             deValid;
    pipePkg::opcodeT                  deOp;
    logic [pipePkg::dataWidth-1:0]    deA;
    logic [pipePkg::dataWidth-1:0]    deB;
    logic [pipePkg::regAddrWidth-1:0] deDest;
    logic [pipePkg::dataWidth-1:0]    dePc4;
    logic [pipePkg::excWidth-1:0]     deExc;
    logic                             deBd;
    logic                             exValid;
    logic [pipePkg::regAddrWidth-1:0] exDest;
    logic [pipePkg::dataWidth-1:0]    exResult;
    logic                             emValid;
    logic [pipePkg::dataWidth-1:0]    emResult;
    logic [pipePkg::regAddrWidth-1:0] emDest;
    logic [pipePkg::dataWidth-1:0]    emPc4;
    logic [pipePkg::excWidth-1:0]     emExc;
    logic                             emBd;
    logic                             wbEn;
    logic [pipePkg::regAddrWidth-1:0] wbAddr;
    logic [pipePkg::dataWidth-1:0]    wbData;
    logic                             flushReq;

    fetchStage uFetch (
        .clk(clk), .arstN(arstN), .insValid(insValid), .insWord(insWord),
        .flushReq(flushReq), .jumpValid(jumpValid), .jumpTarget(jumpTarget),
        .fdValid(fdValid), .fdIns(fdIns), .fdPc4(fdPc4), .fdBd(fdBd), .fetchPc(fetchPc)
    );

    regFile uRegFile (
        .clk(clk), .arstN(arstN), .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
        .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
        .rdDataA(rdDataA), .rdDataB(rdDataB)
    );

    decodeStage uDecode (
        .clk(clk), .arstN(arstN), .fdValid(fdValid), .fdIns(fdIns), .fdPc4(fdPc4),
        .fdBd(fdBd), .rdDataA(rdDataA), .rdDataB(rdDataB), .exValid(exValid),
        .exDest(exDest), .exResult(exResult), .wbEn(wbEn), .wbAddr(wbAddr),
        .wbData(wbData), .flushReq(flushReq), .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
        .jumpValid(jumpValid), .jumpTarget(jumpTarget), .deValid(deValid), .deOp(deOp),
        .deA(deA), .deB(deB), .deDest(deDest), .dePc4(dePc4), .deExc(deExc), .deBd(deBd)
    );

    executeStage uExecute (
        .clk(clk), .arstN(arstN), .deValid(deValid), .deOp(deOp), .deA(deA), .deB(deB),
        .deDest(deDest), .dePc4(dePc4), .deExc(deExc), .deBd(deBd), .flushReq(flushReq),
        .exValid(exValid), .exDest(exDest), .exResult(exResult), .emValid(emValid),
        .emResult(emResult), .emDest(emDest), .emPc4(emPc4), .emExc(emExc), .emBd(emBd)
    );

    commitUnit uCommit (
        .emValid(emValid), .emResult(emResult), .emDest(emDest), .emPc4(emPc4),
        .emExc(emExc), .emBd(emBd), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
        .flushReq(flushReq), .retireValid(retireValid), .retirePc(retirePc),
        .retireDest(retireDest), .retireResult(retireResult), .excValid(excValid),
        .excCode(excCode), .excEpc(excEpc), .excBd(excBd)
    );

endmodule

// File: dv/pipeCoreTb.sv
module pipeCoreTb;

    localparam int numCycles = 3000;
    localparam int arrSize   = numCycles + 8;

    logic                             clk;
    logic                             arstN;
    logic                             insValid;
    logic [pipePkg::dataWidth-1:0]    insWord;
    logic                             retireValid;
    logic [pipePkg::dataWidth-1:0]    retirePc;
    logic [pipePkg::regAddrWidth-1:0] retireDest;
    logic [pipePkg::dataWidth-1:0]    retireResult;
    logic                             excValid;
    logic [pipePkg::excWidth-1:0]     excCode;
    logic [pipePkg::dataWidth-1:0]    excEpc;
    logic                             excBd;
    logic [pipePkg::dataWidth-1:0]    fetchPc;

    // Expected outputs, indexed by the cycle in which they are sampled.
    logic        expRet   [arrSize];
    logic [31:0] expRetPc [arrSize];
    logic [4:0]  expDest  [arrSize];
    logic [31:0] expRes   [arrSize];
    logic        expChk   [arrSize];
    logic        expExc   [arrSize];
    logic [4:0]  expCode  [arrSize];
    logic [31:0] expEpc   [arrSize];
    logic        expBd    [arrSize];
    logic        pcKnown  [arrSize];
    logic [31:0] expPc    [arrSize];

    logic [31:0] modelRegs [32];
    logic [31:0] modelPc;
    logic [31:0] modelTarget;
    logic        jumpPending;
    int          squashUntil;
    int          cyc;
    logic        checking;

    pipeCore UUT (
        .clk(clk), .arstN(arstN), .insValid(insValid), .insWord(insWord),
        .retireValid(retireValid), .retirePc(retirePc), .retireDest(retireDest),
        .retireResult(retireResult), .excValid(excValid), .excCode(excCode),
        .excEpc(excEpc), .excBd(excBd), .fetchPc(fetchPc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic reportMismatch(input string msg);
        $display("mismatch at time %0t: %s", $time, msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    // Registers 0 to 3 only, so that dependencies are frequent.
    function automatic logic [31:0] makeIns();
        logic [31:0] r;
        logic [31:0] f;
        int unsigned pick;
        pick = $urandom % 100;
        r    = $urandom;
        f    = $urandom;
        if (pick < 30) begin
            return {pipePkg::opSpecial, 3'b000, r[1:0], 3'b000, r[3:2], 3'b000, r[5:4],
                    5'd0, pipePkg::functAdd};
        end else if (pick < 52) begin
            return {pipePkg::opAddi, 3'b000, r[1:0], 3'b000, r[3:2], f[15:0]};
        end else if (pick < 64) begin
            return {pipePkg::opOri, 3'b000, r[1:0], 3'b000, r[3:2], f[15:0]};
        end else if (pick < 84) begin
            return {pipePkg::opLui, 5'd0, 3'b000, r[3:2], f[15:0]};
        end else if (pick < 92) begin
            return {pipePkg::opJ, f[25:0]};
        end else if (pick < 96) begin
            return {2'b10, r[9:6], f[25:0]};
        end
        // R-type with a funct other than add.
        return {pipePkg::opSpecial, f[25:6], 1'b0, r[10:6]};
    endfunction

    task automatic stepModel(input int d, input logic strobe, input logic [31:0] ins);
        logic [31:0] pc;
        logic [31:0] seqPc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] nextPc;
        logic [4:0]  dest;
        logic [4:0]  code;
        logic        bd;
        logic        chk;
        logic        isAdd;
        longint      wide;
        if (d <= squashUntil) begin
            // Words taken while the flush is in flight never execute.
            pcKnown[d+1] = (d == squashUntil);
            expPc[d+1]   = pipePkg::handlerPc;
            return;
        end
        pcKnown[d+1] = 1'b1;
        expPc[d+1]   = modelPc;
        if (!strobe) return;
        pc          = modelPc;
        seqPc       = pc + 32'd4;
        bd          = jumpPending;
        nextPc      = jumpPending ? modelTarget : seqPc;
        jumpPending = 1'b0;
        a     = modelRegs[ins[25:21]];
        b     = modelRegs[ins[20:16]];
        res   = '0;
        dest  = '0;
        code  = pipePkg::excNone;
        chk   = 1'b1;
        isAdd = 1'b0;
        case (ins[31:26])
            pipePkg::opSpecial: begin
                if (ins[5:0] == 6'd32) begin
                    isAdd = 1'b1;
                    dest  = ins[15:11];
                end else begin
                    code = pipePkg::excRi;
                end
            end
            pipePkg::opAddi: begin
                isAdd = 1'b1;
                b     = {{16{ins[15]}}, ins[15:0]};
                dest  = ins[20:16];
            end
            pipePkg::opOri: begin
                res  = a | {16'h0000, ins[15:0]};
                dest = ins[20:16];
            end
            pipePkg::opLui: begin
                res  = {ins[15:0], 16'h0000};
                dest = ins[20:16];
            end
            pipePkg::opJ: begin
                chk         = 1'b0;
                jumpPending = 1'b1;
                modelTarget = {seqPc[31:28], ins[25:0], 2'b00};
            end
            default: code = pipePkg::excRi;
        endcase
        if (isAdd) begin
            res  = a + b;
            wide = longint'($signed(a)) + longint'($signed(b));
            if ((wide > 64'sd2147483647) || (wide < -64'sd2147483648)) code = pipePkg::excOv;
        end
        expPc[d+1] = nextPc;
        if (code == pipePkg::excNone) begin
            expRet[d+3]   = 1'b1;
            expRetPc[d+3] = pc;
            expDest[d+3]  = dest;
            expRes[d+3]   = res;
            expChk[d+3]   = chk;
            if (dest != 5'd0) modelRegs[dest] = res;
            modelPc = nextPc;
        end else begin
            expExc[d+3]  = 1'b1;
            expCode[d+3] = code;
            // A delay-slot word reports the word just before it.
            expEpc[d+3]  = bd ? (pc - 32'd4) : pc;
            expBd[d+3]   = bd;
            // The handler fetch starts once the flush has passed.
            modelPc     = pipePkg::handlerPc;
            jumpPending = 1'b0;
            squashUntil = d + 3;
        end
    endtask

    assert property (@(posedge clk) disable iff (!checking)
        (retireValid == expRet[cyc]) && (!expRet[cyc] || ((retirePc == expRetPc[cyc])
        && (retireDest == expDest[cyc]) && (!expChk[cyc] || (retireResult == expRes[cyc])))))
    else reportMismatch($sformatf("retire %0b pc=%h dest=%0d res=%h, expected %0b %h %0d %h",
        $sampled(retireValid), $sampled(retirePc), $sampled(retireDest),
        $sampled(retireResult), expRet[cyc], expRetPc[cyc], expDest[cyc], expRes[cyc]));

    assert property (@(posedge clk) disable iff (!checking)
        (excValid == expExc[cyc]) && (!expExc[cyc] || ((excCode == expCode[cyc])
        && (excEpc == expEpc[cyc]) && (excBd == expBd[cyc]))))
    else reportMismatch($sformatf("exception %0b code=%0d epc=%h bd=%0b, expected %0b %0d %h %0b",
        $sampled(excValid), $sampled(excCode), $sampled(excEpc), $sampled(excBd),
        expExc[cyc], expCode[cyc], expEpc[cyc], expBd[cyc]));

    assert property (@(posedge clk) disable iff (!checking)
        !pcKnown[cyc] || (fetchPc == expPc[cyc]))
    else reportMismatch($sformatf("fetchPc=%h, expected %h", $sampled(fetchPc), expPc[cyc]));

    initial begin
        logic        strobe;
        logic [31:0] word;
        void'($urandom(32'h1cfe_95ae));
        arstN    = 1'b0;
        insValid = 1'b0;
        insWord  = '0;
        checking = 1'b0;
        cyc      = 0;
        for (int i = 0; i < arrSize; i++) begin
            expRet[i]  = 1'b0;
            expExc[i]  = 1'b0;
            pcKnown[i] = 1'b0;
        end
        for (int i = 0; i < 32; i++) modelRegs[i] = '0;
        modelPc     = pipePkg::resetPc;
        jumpPending = 1'b0;
        squashUntil = -1;
        pcKnown[0]  = 1'b1;
        expPc[0]    = pipePkg::resetPc;
        pcKnown[1]  = 1'b1;
        expPc[1]    = pipePkg::resetPc;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);
        assert ((retireValid == 1'b0) && (excValid == 1'b0) && (fetchPc == pipePkg::resetPc))
        else reportMismatch($sformatf("after reset retire=%0b exc=%0b fetchPc=%h",
            retireValid, excValid, fetchPc));
        checking = 1'b1;
        for (int d = 1; d <= numCycles + 6; d++) begin
            @(negedge clk);
            cyc      = d;
            strobe   = (d <= numCycles) && (($urandom % 10) < 7);
            word     = makeIns();
            insValid = strobe;
            insWord  = strobe ? word : $urandom;
            stepModel(d, strobe, word);
        end
        @(negedge clk);
        $display("PASS: all tests");
        $finish;
    end

    // Stimulus length plus margin for reset and drain.
    initial begin
        #((numCycles + 100) * 10);
        $display("timeout: the run did not finish in the expected time");
        $display("FAIL: see errors above");
        $fatal(1);
    end

endmodule

// File: tb.f
logic/pipePkg.sv
logic/regFile.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/commitUnit.sv
logic/pipeCore.sv
dv/pipeCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run the simulation.
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f tb.f --top-module pipeCoreTb \
        -Mdir obj_dir -o pipeCoreSim; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/pipeCoreSim; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without errors"
exit 0
